/* Makefile */
# Verilator flow for the multicycle control unit

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+source \
		source/cu_pkg.sv source/instr_decoder.sv source/main_fsm.sv \
		source/control_outputs.sv source/control_unit.sv \
		--top-module control_unit

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
		--top-module tb_control_unit -o tb_control_unit
	./obj_dir/tb_control_unit 2>&1 | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
+incdir+source
source/cu_pkg.sv
source/instr_decoder.sv
source/main_fsm.sv
source/control_outputs.sv
source/control_unit.sv
testbench/tb_control_unit.sv

/* source/control_outputs.sv */
`timescale 1ns/1ps

module control_outputs
    import cu_pkg::*;
(
    input  state_e     state,
    input  alu_op_e    exec_alu_op,
    input  alu_src_b_e exec_src_b,
    input  reg_dst_e   dest_reg,
    input  logic       jump_register,
    input  logic       zero,
    output logic       pc_en,
    output logic       mem_write,
    output logic       reg_write,
    output logic       branch,
    output logic       illegal_instr,
    output alu_op_e    alu_control,
    output alu_src_b_e alu_src_b,
    output reg_dst_e   reg_dst,
    output wb_sel_e    mem_to_reg,
    output pc_src_e    pc_src
);

    // Unconditional PC update, requested in FETCH and JUMP
    logic pc_write;

    // Every output starts inactive and each state raises only what it needs.
    // The states not listed here (IDLE, DECODE, JUMP_SETTLE, DONE) keep the defaults
    always_comb
    begin
        pc_write      = 1'b0;
        mem_write     = 1'b0;
        reg_write     = 1'b0;
        branch        = 1'b0;
        illegal_instr = 1'b0;
        alu_control   = ALU_ADD;
        alu_src_b     = SRC_B_REG;
        reg_dst       = DST_RT;
        mem_to_reg    = WB_ALU;
        pc_src        = PC_SRC_ALU;

        case (state)
            S_FETCH:
            begin
                // PC + 4 through the ALU, written straight back into the PC
                pc_write  = 1'b1;
                alu_src_b = SRC_B_FOUR;
                alu_control = ALU_ADD;
                pc_src    = PC_SRC_ALU;
            end
            S_EXECUTE:
            begin
                // Operation and operand B come from the instruction decoder
                alu_control = exec_alu_op;
                alu_src_b   = exec_src_b;
            end
            S_WRITE_BACK:
            begin
                reg_write  = 1'b1;
                reg_dst    = dest_reg;
                mem_to_reg = WB_ALU;
            end
            S_MEM_ADDR:
            begin
                // Base register plus sign extended offset
                alu_src_b   = SRC_B_IMM;
                alu_control = ALU_ADD;
            end
            S_STORE:
            begin
                mem_write = 1'b1;
            end
            S_LOAD:
            begin
                reg_write  = 1'b1;
                reg_dst    = DST_RT;
                mem_to_reg = WB_MEM;
            end
            S_BRANCH_ADDR:
            begin
                // Target is PC + 4 plus the word offset, kept in ALU out
                alu_src_b   = SRC_B_IMM_SHIFTED;
                alu_control = ALU_ADD;
            end
            S_COMPARE_EQ:
            begin
                // rs - rt sets zero when the registers match
                alu_control = ALU_SUB;
                pc_src      = PC_SRC_ALU_OUT;
                branch      = zero;
            end
            S_COMPARE_NE:
            begin
                alu_control = ALU_SUB;
                pc_src      = PC_SRC_ALU_OUT;
                branch      = ~zero;
            end
            S_JUMP:
            begin
                pc_write = 1'b1;
                if (jump_register)
                begin
                    pc_src = PC_SRC_JR;
                end
                else
                begin
                    pc_src = PC_SRC_JUMP;
                end
            end
            S_UNDEFINED:
            begin
                illegal_instr = 1'b1;
            end
            default:
            begin
                pc_write = 1'b0;
            end
        endcase
    end

    // A taken branch loads the PC just like an unconditional write
    assign pc_en = pc_write | branch;

    // The register file and the data memory are never written in the same cycle
    always_comb
    begin
        a_no_dual_write: assert final (!(mem_write && reg_write));
    end

    // The ALU flag may move the PC only while a compare is in progress
    always_comb
    begin
        a_branch_in_compare: assert final
            (!branch || state inside {S_COMPARE_EQ, S_COMPARE_NE});
    end

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import cu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  opcode_e    opcode,
    input  funct_e     funct,
    input  logic       zero,
    output logic       pc_en,
    output logic       mem_write,
    output logic       reg_write,
    output logic       branch,
    output logic       illegal_instr,
    output alu_op_e    alu_control,
    output alu_src_b_e alu_src_b,
    output reg_dst_e   reg_dst,
    output wb_sel_e    mem_to_reg,
    output pc_src_e    pc_src
);

    // Decoded instruction fields, stable for the whole instruction
    instr_class_e instr_class;
    alu_op_e      exec_alu_op;
    alu_src_b_e   exec_src_b;
    reg_dst_e     dest_reg;
    logic         jump_register;

    // Current sequencer state
    state_e       state;

    instr_decoder instr_decoder_i (
        .opcode        (opcode),
        .funct         (funct),
        .instr_class   (instr_class),
        .exec_alu_op   (exec_alu_op),
        .exec_src_b    (exec_src_b),
        .dest_reg      (dest_reg),
        .jump_register (jump_register)
    );

    main_fsm main_fsm_i (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .state       (state)
    );

    // All datapath controls are decoded from the state in one place
    control_outputs control_outputs_i (
        .state         (state),
        .exec_alu_op   (exec_alu_op),
        .exec_src_b    (exec_src_b),
        .dest_reg      (dest_reg),
        .jump_register (jump_register),
        .zero          (zero),
        .pc_en         (pc_en),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .branch        (branch),
        .illegal_instr (illegal_instr),
        .alu_control   (alu_control),
        .alu_src_b     (alu_src_b),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_src        (pc_src)
    );

endmodule

/* source/cu_cfg.svh */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// Width of the primary opcode field, instruction bits 31:26
`define CU_OPCODE_W 6

// Width of the R-type function field, instruction bits 5:0
`define CU_FUNCT_W 6

// Width of the ALU operation select driven to the datapath
`define CU_ALU_CTRL_W 4

// Every defined instruction spends this many cycles from FETCH to DONE.
// The sequencer checks it and the testbench counts against it
`define CU_CYCLES_PER_INSTR 5

`endif

/* source/cu_pkg.sv */
`include "cu_cfg.svh"

package cu_pkg;

    // Primary opcodes kept by this control unit
    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // Function codes that qualify OP_RTYPE
    typedef enum logic [`CU_FUNCT_W-1:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    // Coarse instruction class, the only thing the sequencer branches on
    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BEQ,
        CLASS_BNE,
        CLASS_JUMP,
        CLASS_ILLEGAL
    } instr_class_e;

    // Multicycle sequencer states.
    // The code 4'hF is unused and treated as out of range
    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_WRITE_BACK,
        S_MEM_ADDR,
        S_STORE,
        S_LOAD,
        S_BRANCH_ADDR,
        S_COMPARE_EQ,
        S_COMPARE_NE,
        S_JUMP,
        S_JUMP_SETTLE,
        S_DONE,
        S_UNDEFINED
    } state_e;

    // ALU operation codes, as the datapath ALU decodes them
    typedef enum logic [`CU_ALU_CTRL_W-1:0] {
        ALU_AND = 4'd0,
        ALU_SUB = 4'd1,
        ALU_ADD = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_LUI = 4'd5
    } alu_op_e;

    // Second ALU operand select: register, constant four, immediate, immediate << 2
    typedef enum logic [1:0] {
        SRC_B_REG          = 2'd0,
        SRC_B_FOUR         = 2'd1,
        SRC_B_IMM          = 2'd2,
        SRC_B_IMM_SHIFTED  = 2'd3
    } alu_src_b_e;

    // Register file write address select
    typedef enum logic {
        DST_RT,
        DST_RD
    } reg_dst_e;

    // Register file write data select
    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    // Next PC select
    typedef enum logic [1:0] {
        PC_SRC_ALU,
        PC_SRC_ALU_OUT,
        PC_SRC_JUMP,
        PC_SRC_JR
    } pc_src_e;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import cu_pkg::*;
(
    input  opcode_e      opcode,
    input  funct_e       funct,
    output instr_class_e instr_class,
    output alu_op_e      exec_alu_op,
    output alu_src_b_e   exec_src_b,
    output reg_dst_e     dest_reg,
    output logic         jump_register
);

    // Pure lookup of the instruction fields.
    // The opcode and funct are held stable by the datapath for the whole
    // instruction, so the outputs stay valid from FETCH through DONE
    always_comb
    begin
        // Defaults describe an instruction that needs no ALU help of its own
        instr_class   = CLASS_ILLEGAL;
        exec_alu_op   = ALU_ADD;
        exec_src_b    = SRC_B_REG;
        dest_reg      = DST_RT;
        jump_register = 1'b0;

        case (opcode)
            OP_RTYPE:
            begin
                // Register operands on both ALU inputs, result goes to rd
                exec_src_b = SRC_B_REG;
                dest_reg   = DST_RD;
                case (funct)
                    FN_ADD:
                    begin
                        instr_class = CLASS_ALU;
                        exec_alu_op = ALU_ADD;
                    end
                    FN_SUB:
                    begin
                        instr_class = CLASS_ALU;
                        exec_alu_op = ALU_SUB;
                    end
                    FN_AND:
                    begin
                        instr_class = CLASS_ALU;
                        exec_alu_op = ALU_AND;
                    end
                    FN_OR:
                    begin
                        instr_class = CLASS_ALU;
                        exec_alu_op = ALU_OR;
                    end
                    FN_SLT:
                    begin
                        instr_class = CLASS_ALU;
                        exec_alu_op = ALU_SLT;
                    end
                    FN_JR:
                    begin
                        // jr shares the jump path, the PC comes from rs
                        instr_class   = CLASS_JUMP;
                        jump_register = 1'b1;
                    end
                    default:
                    begin
                        instr_class = CLASS_ILLEGAL;
                    end
                endcase
            end
            // Immediate arithmetic writes rt and takes the immediate as operand B
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI:
            begin
                instr_class = CLASS_ALU;
                exec_src_b  = SRC_B_IMM;
                dest_reg    = DST_RT;
                case (opcode)
                    OP_SLTI: exec_alu_op = ALU_SLT;
                    OP_ANDI: exec_alu_op = ALU_AND;
                    OP_ORI:  exec_alu_op = ALU_OR;
                    OP_LUI:  exec_alu_op = ALU_LUI;
                    default: exec_alu_op = ALU_ADD;
                endcase
            end
            OP_LW:
            begin
                instr_class = CLASS_LOAD;
            end
            OP_SW:
            begin
                instr_class = CLASS_STORE;
            end
            OP_BEQ:
            begin
                instr_class = CLASS_BEQ;
            end
            OP_BNE:
            begin
                instr_class = CLASS_BNE;
            end
            OP_J:
            begin
                instr_class = CLASS_JUMP;
            end
            default:
            begin
                instr_class = CLASS_ILLEGAL;
            end
        endcase
    end

endmodule

/* source/main_fsm.sv */
`timescale 1ns/1ps

`include "cu_cfg.svh"

module main_fsm
    import cu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instr_class_e instr_class,
    output state_e       state
);

    state_e next_state;

    // Sequencer transitions.
    // Every legal path is five states long, counted from FETCH to DONE
    always_comb
    begin
        next_state = S_IDLE;
        case (state)
            S_IDLE:        next_state = S_FETCH;
            S_FETCH:       next_state = S_DECODE;
            S_DECODE:
            begin
                // The decoder class picks the third state of the sequence
                case (instr_class)
                    CLASS_ALU:              next_state = S_EXECUTE;
                    CLASS_LOAD, CLASS_STORE: next_state = S_MEM_ADDR;
                    CLASS_BEQ, CLASS_BNE:   next_state = S_BRANCH_ADDR;
                    CLASS_JUMP:             next_state = S_JUMP;
                    default:                next_state = S_UNDEFINED;
                endcase
            end
            S_EXECUTE:     next_state = S_WRITE_BACK;
            S_WRITE_BACK:  next_state = S_DONE;
            S_MEM_ADDR:
            begin
                if (instr_class == CLASS_STORE)
                begin
                    next_state = S_STORE;
                end
                else
                begin
                    next_state = S_LOAD;
                end
            end
            S_STORE:       next_state = S_DONE;
            S_LOAD:        next_state = S_DONE;
            S_BRANCH_ADDR:
            begin
                // Equal and not-equal compares differ only in the branch sense
                if (instr_class == CLASS_BEQ)
                begin
                    next_state = S_COMPARE_EQ;
                end
                else
                begin
                    next_state = S_COMPARE_NE;
                end
            end
            S_COMPARE_EQ:  next_state = S_DONE;
            S_COMPARE_NE:  next_state = S_DONE;
            // One extra cycle lets the new PC reach the instruction memory
            S_JUMP:        next_state = S_JUMP_SETTLE;
            S_JUMP_SETTLE: next_state = S_DONE;
            S_DONE:        next_state = S_FETCH;
            // An undefined instruction leaves through IDLE
            S_UNDEFINED:   next_state = S_IDLE;
            default:       next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // The unused encoding 4'hF must never be reached
    a_state_in_range: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(state) && state <= S_UNDEFINED);

    // Decode always follows fetch, whatever the instruction turns out to be
    a_fetch_then_decode: assert property (@(posedge clk) disable iff (!reset)
        state == S_FETCH |=> state == S_DECODE);

    // Instruction length bound, relaxed only on the illegal path
    a_fetch_recurs: assert property (@(posedge clk) disable iff (!reset)
        state == S_FETCH |->
            ##[1:`CU_CYCLES_PER_INSTR] (state inside {S_FETCH, S_UNDEFINED}));

endmodule

/* testbench/tb_control_unit.sv */
`timescale 1ns/1ps

`include "cu_cfg.svh"

module tb_control_unit
    import cu_pkg::*;
();

    // Packed control vector holding pc_en, mem_write, reg_write, branch, illegal_instr,
    // alu_control, alu_src_b, reg_dst, mem_to_reg and pc_src from the top bit down
    localparam int VEC_W = 15;

    // Longest legal gap before a FETCH shows up plus some margin
    localparam int FETCH_TIMEOUT = 2 * `CU_CYCLES_PER_INSTR;

    logic       clk;
    logic       reset;
    opcode_e    opcode;
    funct_e     funct;
    logic       zero;
    logic       pc_en;
    logic       mem_write;
    logic       reg_write;
    logic       branch;
    logic       illegal_instr;
    alu_op_e    alu_control;
    alu_src_b_e alu_src_b;
    reg_dst_e   reg_dst;
    wb_sel_e    mem_to_reg;
    pc_src_e    pc_src;

    // Expected per-cycle vectors of the instruction under test, FETCH first
    logic [VEC_W-1:0] expected_seq[$];

    // Table of legal instructions used by the directed and the random tests
    string       instr_names[$];
    opcode_e     instr_ops[$];
    funct_e      instr_fns[$];

    control_unit control_unit_i (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .zero          (zero),
        .pc_en         (pc_en),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .branch        (branch),
        .illegal_instr (illegal_instr),
        .alu_control   (alu_control),
        .alu_src_b     (alu_src_b),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .pc_src        (pc_src)
    );

    // 100 ns clock period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [VEC_W-1:0] make_vector(
        input logic pc, input logic mw, input logic rw, input logic br, input logic ill,
        input alu_op_e alu, input alu_src_b_e src_b, input reg_dst_e dst,
        input wb_sel_e wb, input pc_src_e pcs);
        return {pc, mw, rw, br, ill, alu, src_b, dst, wb, pcs};
    endfunction

    // Everything inactive, as in reset, IDLE, DECODE, JUMP_SETTLE and DONE
    function automatic logic [VEC_W-1:0] idle_vector();
        return make_vector(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD, SRC_B_REG, DST_RT,
            WB_ALU, PC_SRC_ALU);
    endfunction

    // PC + 4 written back into the PC
    function automatic logic [VEC_W-1:0] fetch_vector();
        return make_vector(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD, SRC_B_FOUR, DST_RT,
            WB_ALU, PC_SRC_ALU);
    endfunction

    function automatic logic [VEC_W-1:0] observed_vector();
        return {pc_en, mem_write, reg_write, branch, illegal_instr, alu_control,
            alu_src_b, reg_dst, mem_to_reg, pc_src};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
        input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                $time, what, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add_instr(input string name, input opcode_e op, input funct_e fn);
        instr_names.push_back(name);
        instr_ops.push_back(op);
        instr_fns.push_back(fn);
    endtask

    // EXECUTE with the decoded operation, WRITE_BACK into rt or rd, then DONE
    task automatic alu_steps(input alu_op_e op, input alu_src_b_e src_b, input reg_dst_e dst);
        expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, op, src_b, DST_RT,
            WB_ALU, PC_SRC_ALU));
        expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, ALU_ADD, SRC_B_REG,
            dst, WB_ALU, PC_SRC_ALU));
        expected_seq.push_back(idle_vector());
    endtask

    // Address add, then the memory write or the load into rt
    task automatic memory_steps(input logic is_store);
        expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD, SRC_B_IMM,
            DST_RT, WB_ALU, PC_SRC_ALU));
        if (is_store)
        begin
            expected_seq.push_back(make_vector(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, ALU_ADD,
                SRC_B_REG, DST_RT, WB_ALU, PC_SRC_ALU));
        end
        else
        begin
            expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, ALU_ADD,
                SRC_B_REG, DST_RT, WB_MEM, PC_SRC_ALU));
        end
        expected_seq.push_back(idle_vector());
    endtask

    // Target add, then a subtract whose result decides the PC load
    task automatic branch_steps(input logic taken);
        expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD,
            SRC_B_IMM_SHIFTED, DST_RT, WB_ALU, PC_SRC_ALU));
        expected_seq.push_back(make_vector(taken, 1'b0, 1'b0, taken, 1'b0, ALU_SUB,
            SRC_B_REG, DST_RT, WB_ALU, PC_SRC_ALU_OUT));
        expected_seq.push_back(idle_vector());
    endtask

    // JUMP loads the PC while JUMP_SETTLE and DONE are quiet
    task automatic jump_steps(input pc_src_e target);
        expected_seq.push_back(make_vector(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ALU_ADD, SRC_B_REG,
            DST_RT, WB_ALU, target));
        expected_seq.push_back(idle_vector());
        expected_seq.push_back(idle_vector());
    endtask

    // One cycle of illegal_instr, then the quiet IDLE cycle
    task automatic illegal_steps();
        expected_seq.push_back(make_vector(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, ALU_ADD, SRC_B_REG,
            DST_RT, WB_ALU, PC_SRC_ALU));
        expected_seq.push_back(idle_vector());
    endtask

    // Reference model of the whole control sequence of one instruction
    task automatic build_expected(input opcode_e op, input funct_e fn, input logic z);
        expected_seq.delete();
        expected_seq.push_back(fetch_vector());
        expected_seq.push_back(idle_vector());
        case (op)
            OP_RTYPE:
            begin
                case (fn)
                    FN_ADD:  alu_steps(ALU_ADD, SRC_B_REG, DST_RD);
                    FN_SUB:  alu_steps(ALU_SUB, SRC_B_REG, DST_RD);
                    FN_AND:  alu_steps(ALU_AND, SRC_B_REG, DST_RD);
                    FN_OR:   alu_steps(ALU_OR, SRC_B_REG, DST_RD);
                    FN_SLT:  alu_steps(ALU_SLT, SRC_B_REG, DST_RD);
                    FN_JR:   jump_steps(PC_SRC_JR);
                    default: illegal_steps();
                endcase
            end
            OP_ADDI: alu_steps(ALU_ADD, SRC_B_IMM, DST_RT);
            OP_SLTI: alu_steps(ALU_SLT, SRC_B_IMM, DST_RT);
            OP_ANDI: alu_steps(ALU_AND, SRC_B_IMM, DST_RT);
            OP_ORI:  alu_steps(ALU_OR, SRC_B_IMM, DST_RT);
            OP_LUI:  alu_steps(ALU_LUI, SRC_B_IMM, DST_RT);
            OP_LW:   memory_steps(1'b0);
            OP_SW:   memory_steps(1'b1);
            OP_BEQ:  branch_steps(z);
            OP_BNE:  branch_steps(~z);
            OP_J:    jump_steps(PC_SRC_JUMP);
            default: illegal_steps();
        endcase
    endtask

    // FETCH is the only state with pc_en and the constant four on operand B
    task automatic wait_for_fetch(input string name, output int waited);
        waited = 0;
        while (!(pc_en === 1'b1 && alu_src_b === SRC_B_FOUR))
        begin
            if (waited >= FETCH_TIMEOUT)
            begin
                $display("timeout: no FETCH cycle within %0d cycles for %s",
                    FETCH_TIMEOUT, name);
                $display("*** FAILED ***");
                $fatal(1, "FETCH never came");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Inputs change just after the edge that starts FETCH and hold for the
    // whole instruction. Outputs are compared at the falling edge
    task automatic run_instr(input string name, input opcode_e op, input funct_e fn,
        input logic z);
        int waited;
        int i;
        @(posedge clk);
        #1;
        opcode = op;
        funct  = fn;
        zero   = z;
        @(negedge clk);
        wait_for_fetch(name, waited);
        // Instructions run back to back, so FETCH is due right away
        compare_value({name, ": cycles before FETCH"}, 32'(waited), 32'd0);
        build_expected(op, fn, z);
        for (i = 0; i < expected_seq.size(); i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
            end
            compare_value($sformatf("%s cycle %0d", name, i), 32'(observed_vector()),
                32'(expected_seq[i]));
        end
    endtask

    task automatic run_by_index(input int idx, input logic z);
        run_instr(instr_names[idx], instr_ops[idx], instr_fns[idx], z);
    endtask

    task automatic reset_and_startup();
        int i;
        reset = 1'b0;
        for (i = 0; i < 5; i++)
        begin
            @(negedge clk);
            compare_value("outputs in reset", 32'(observed_vector()), 32'(idle_vector()));
        end
        @(posedge clk);
        #1;
        reset = 1'b1;
        // The release cycle is IDLE and FETCH follows in the first instruction
        @(negedge clk);
        compare_value("first cycle after reset", 32'(observed_vector()),
            32'(idle_vector()));
    endtask

    task automatic alu_sequences();
        int i;
        for (i = 0; i < 10; i++)
        begin
            run_by_index(i, 1'($urandom_range(1, 0)));
        end
    endtask

    task automatic memory_sequences();
        run_by_index(10, 1'b0);
        run_by_index(11, 1'b1);
    endtask

    // Both branch senses with zero low and high
    task automatic branch_sequences();
        int i;
        int z;
        for (i = 12; i < 14; i++)
        begin
            for (z = 0; z < 2; z++)
            begin
                run_by_index(i, 1'(z));
            end
        end
    endtask

    task automatic jump_sequences();
        run_by_index(14, 1'b0);
        run_by_index(15, 1'b1);
    endtask

    // Undefined encodings, then a random run of legal ones
    task automatic illegal_recovery();
        int i;
        int idx;
        run_instr("illegal opcode", opcode_e'(6'h3F), FN_ADD, 1'b0);
        run_instr("illegal funct", OP_RTYPE, funct_e'(6'h3F), 1'b0);
        for (i = 0; i < 24; i++)
        begin
            idx = int'($urandom_range(15, 0));
            run_by_index(idx, 1'($urandom_range(1, 0)));
        end
    endtask

    initial
    begin
        reset  = 1'b0;
        opcode = OP_RTYPE;
        funct  = FN_ADD;
        zero   = 1'b0;
        void'($urandom(32'h0db0_49b0));

        add_instr("add", OP_RTYPE, FN_ADD);
        add_instr("sub", OP_RTYPE, FN_SUB);
        add_instr("and", OP_RTYPE, FN_AND);
        add_instr("or", OP_RTYPE, FN_OR);
        add_instr("slt", OP_RTYPE, FN_SLT);
        add_instr("addi", OP_ADDI, FN_ADD);
        add_instr("slti", OP_SLTI, FN_ADD);
        add_instr("andi", OP_ANDI, FN_ADD);
        add_instr("ori", OP_ORI, FN_ADD);
        add_instr("lui", OP_LUI, FN_ADD);
        add_instr("lw", OP_LW, FN_ADD);
        add_instr("sw", OP_SW, FN_ADD);
        add_instr("beq", OP_BEQ, FN_ADD);
        add_instr("bne", OP_BNE, FN_ADD);
        add_instr("j", OP_J, FN_ADD);
        add_instr("jr", OP_RTYPE, FN_JR);

        reset_and_startup();
        alu_sequences();
        memory_sequences();
        branch_sequences();
        jump_sequences();
        illegal_recovery();

        $display("*** PASSED ***");
        $finish;
    end

endmodule
